/* Makefile */
# Verilator build and run of the multicycle RV32I core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_TEXT := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
source/rvPkg.sv
source/aluUnit.sv
source/regFile.sv
source/controlUnit.sv
source/dataPath.sv
source/cpuTop.sv
sim/wbMemory.sv
sim/cpuTb.sv

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;
    import rvPkg::*;

    localparam int numTests = 6;
    localparam int maxInstr = 16;

    logic        clk;
    logic        rst;
    wbReqT       busReq;
    wbRspT       busRsp;
    logic [31:0] instRetired;

    string       testName [numTests];
    logic [31:0] prog     [numTests][maxInstr];
    int          progLen  [numTests];
    logic [31:0] expAdr   [numTests];
    logic [31:0] expVal   [numTests];
    logic [31:0] dataAdr  [numTests][2];   // Data words placed before the run
    logic [31:0] dataVal  [numTests][2];
    int          testErrors;
    int          passCount;
    int          failCount;
    logic        tableReady;
    wbReqT       storeReq;

    cpuTop dut_i (
        .clk         (clk),
        .rst         (rst),
        .busReq      (busReq),
        .busRsp      (busRsp),
        .instRetired (instRetired)
    );

    wbMemory mem_i (
        .clk (clk),
        .rst (rst),
        .req (busReq),
        .rsp (busRsp)
    );

    initial clk = 1'b1;
    always #20 clk = ~clk;

    // Small assembler for the formats under test
    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRegReg};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd);
        return {imm, rs1, f3, rd, opRegImm};
    endfunction

    function automatic logic [31:0] encLw(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
        return {imm, rs1, 3'b010, rd, opLoad};
    endfunction

    function automatic logic [31:0] encSw(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    task automatic addInstr(input int t, input logic [31:0] word);
        prog[t][progLen[t]] = word;
        progLen[t]          = progLen[t] + 1;
    endtask

    task automatic newTest(input int t, input string name, input logic [31:0] adr,
                           input logic [31:0] val);
        testName[t]   = name;
        progLen[t]    = 0;
        expAdr[t]     = adr;
        expVal[t]     = val;
        dataAdr[t][0] = 32'h300;
        dataVal[t][0] = 32'h0;
        dataAdr[t][1] = 32'h304;
        dataVal[t][1] = 32'h0;
    endtask

    task automatic buildTable();
        newTest(0, "regRegAlu", 32'h200, 32'hFFFFFF94);
        addInstr(0, encI(12'd100, 5'd0, 3'b000, 5'd1));
        addInstr(0, encI(12'hFF9, 5'd0, 3'b000, 5'd2));       // -7
        addInstr(0, encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));   // ADD 93
        addInstr(0, encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));   // SUB 107
        addInstr(0, encR(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));   // AND 0x49
        addInstr(0, encR(7'h00, 5'd1, 5'd5, 3'b110, 5'd6));   // OR 0x6D
        addInstr(0, encR(7'h00, 5'd2, 5'd6, 3'b100, 5'd7));   // XOR
        addInstr(0, encSw(12'h200, 5'd7, 5'd0));

        newTest(1, "cmpShift", 32'h204, 32'hDFFFFF81);
        addInstr(1, encI(12'hFF0, 5'd0, 3'b000, 5'd1));       // -16
        addInstr(1, encI(12'd35, 5'd0, 3'b000, 5'd2));        // Shifts by 3
        addInstr(1, encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));   // SLT 1
        addInstr(1, encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd4));   // SLTU 0
        addInstr(1, encR(7'h20, 5'd2, 5'd1, 3'b101, 5'd6));   // SRA 0xFFFFFFFE
        addInstr(1, encR(7'h00, 5'd2, 5'd1, 3'b101, 5'd7));   // SRL 0x1FFFFFFE
        addInstr(1, encR(7'h00, 5'd2, 5'd1, 3'b001, 5'd8));   // SLL 0xFFFFFF80
        addInstr(1, encR(7'h00, 5'd7, 5'd6, 3'b100, 5'd9));
        addInstr(1, encR(7'h00, 5'd8, 5'd9, 3'b000, 5'd10));
        addInstr(1, encR(7'h20, 5'd4, 5'd3, 3'b000, 5'd12));
        addInstr(1, encR(7'h00, 5'd12, 5'd10, 3'b000, 5'd13));
        addInstr(1, encSw(12'h204, 5'd13, 5'd0));

        newTest(2, "immForms", 32'h208, 32'h01000004);
        addInstr(2, encI(12'hED4, 5'd0, 3'b000, 5'd1));       // -300
        addInstr(2, encI(12'h0FF, 5'd1, 3'b111, 5'd2));       // ANDI 0xD4
        addInstr(2, encI(12'hF00, 5'd2, 3'b110, 5'd3));       // ORI 0xFFFFFFD4
        addInstr(2, encI(12'h555, 5'd3, 3'b100, 5'd4));       // XORI 0xFFFFFA81
        addInstr(2, encI(12'hED5, 5'd1, 3'b010, 5'd5));       // SLTI -299 gives 1
        addInstr(2, encI(12'd5, 5'd1, 3'b011, 5'd6));         // SLTIU gives 0
        addInstr(2, encI(12'd4, 5'd5, 3'b001, 5'd7));         // SLLI 16
        addInstr(2, encI(12'd8, 5'd4, 3'b101, 5'd8));         // SRLI 0x00FFFFFA
        addInstr(2, encI(12'h408, 5'd4, 3'b101, 5'd9));       // SRAI 0xFFFFFFFA
        addInstr(2, encR(7'h00, 5'd9, 5'd8, 3'b000, 5'd10));
        addInstr(2, encR(7'h00, 5'd7, 5'd10, 3'b000, 5'd11));
        addInstr(2, encR(7'h20, 5'd6, 5'd11, 3'b000, 5'd12));
        addInstr(2, encSw(12'h208, 5'd12, 5'd0));

        newTest(3, "loadStore", 32'h20C, 32'h12346122);
        dataAdr[3][0] = 32'h100;
        dataVal[3][0] = 32'h12345678;
        dataAdr[3][1] = 32'h104;
        dataVal[3][1] = 32'h00000AAA;
        addInstr(3, encI(12'h0F0, 5'd0, 3'b000, 5'd1));
        addInstr(3, encLw(12'd16, 5'd1, 5'd2));               // 0x100
        addInstr(3, encI(12'h110, 5'd0, 3'b000, 5'd3));
        addInstr(3, encLw(12'hFF4, 5'd3, 5'd4));              // 0x110 - 12
        addInstr(3, encR(7'h00, 5'd4, 5'd2, 3'b000, 5'd5));
        addInstr(3, encSw(12'h20C, 5'd5, 5'd0));

        newTest(4, "unknownOp", 32'h210, 32'd78);
        addInstr(4, encI(12'd77, 5'd0, 3'b000, 5'd1));
        addInstr(4, 32'h000000FF);                            // Opcode 0x7F with rd x1
        addInstr(4, encI(12'd1, 5'd1, 3'b000, 5'd1));
        addInstr(4, encSw(12'h210, 5'd1, 5'd0));

        newTest(5, "x0Hold", 32'h214, 32'd0);
        addInstr(5, encI(12'd9, 5'd0, 3'b000, 5'd1));
        addInstr(5, encI(12'd55, 5'd0, 3'b000, 5'd0));
        addInstr(5, encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        addInstr(5, encSw(12'h214, 5'd0, 5'd0));
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
            testErrors = testErrors + 1;
        end
    endtask

    task automatic checkReq(input string name, input wbReqT exp, input wbReqT act);
        if (act !== exp) begin
            $display("Error %s: expected request %h, actual %h", name, exp, act);
            testErrors = testErrors + 1;
        end
    endtask

    task automatic checkCount(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("Error %s: expected retired %0d, actual %0d", name, exp, act);
            testErrors = testErrors + 1;
        end
    endtask

    task automatic loadMemory(input int t);
        for (int a = 0; a < 1024; a++) begin
            mem_i.mem[a] = 32'hC0DE0000 ^ (a * 32'h00010001);  // Differs per word
        end
        for (int k = 0; k < progLen[t]; k++) begin
            mem_i.mem[k] = prog[t][k];
        end
        mem_i.mem[dataAdr[t][0][11:2]] = dataVal[t][0];
        mem_i.mem[dataAdr[t][1][11:2]] = dataVal[t][1];
    endtask

    task automatic runTest(input int t);
        wbReqT expReq;
        testErrors = 0;
        @(negedge clk);
        rst = 1'b1;
        loadMemory(t);
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // Each program holds one store, its last instruction
        forever begin
            @(posedge clk);
            if (busRsp.ack && busReq.cyc && busReq.we) begin
                storeReq = busReq;
                break;
            end
        end
        @(posedge clk);                     // Writeback of the store retires it
        @(negedge clk);
        expReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: expAdr[t], dat: expVal[t], sel: 4'hF};
        checkWord(testName[t], expVal[t], storeReq.dat);
        checkWord(testName[t], expAdr[t], storeReq.adr);
        checkReq(testName[t], expReq, mem_i.lastWrite);
        checkCount(testName[t], progLen[t], instRetired);
        if (testErrors == 0) begin
            $display("Test %s passed", testName[t]);
            passCount = passCount + 1;
        end else begin
            $display("Test %s failed with %0d errors", testName[t], testErrors);
            failCount = failCount + 1;
        end
    endtask

    // Twice the worst case of 12 cycles per instruction plus reset
    initial begin
        longint limitNs;
        int     totalInstr;
        wait (tableReady);
        totalInstr = 0;
        for (int t = 0; t < numTests; t++) begin
            totalInstr = totalInstr + progLen[t];
        end
        limitNs = 2 * (totalInstr * (4 + 2 * 4) + numTests * 6) * 40;
        #(limitNs);
        $display("Timeout: the programs did not finish within %0d ns", limitNs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(39358));
        rst        = 1'b1;
        tableReady = 1'b0;
        passCount  = 0;
        failCount  = 0;
        buildTable();
        tableReady = 1'b1;
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/wbMemory.sv */
`timescale 1ns/1ps

module wbMemory (
    input  logic         clk,
    input  logic         rst,
    input  rvPkg::wbReqT req,
    output rvPkg::wbRspT rsp
);
    import rvPkg::*;

    logic [31:0] mem [0:1023];              // 4 KB of word-addressed storage
    logic        busy;
    int unsigned waitLeft;
    wbReqT       lastWrite;                 // Most recent completed write

    // Responses move on the falling edge and stay stable for the rising one
    always @(negedge clk) begin
        if (rst) begin
            rsp       <= '0;
            busy      = 1'b0;
            waitLeft  = 0;
            lastWrite = '0;
        end else if (rsp.ack) begin
            rsp.ack <= 1'b0;                // Ack lasts one cycle
        end else if (req.cyc && req.stb) begin
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = $urandom % 4;    // 0 to 3 wait cycles
            end
            if (waitLeft == 0) begin
                busy    = 1'b0;
                rsp.ack <= 1'b1;
                if (req.we) begin
                    mem[req.adr[11:2]] = req.dat;
                    lastWrite          = req;
                end else begin
                    rsp.dat <= mem[req.adr[11:2]];
                end
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOpT op,
    output logic [31:0]  result
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[4:0];           // Only the low 5 bits shift
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluSlt: begin
                result = {{(xlen-1){1'b0}}, lessSigned};
            end
            aluSltu: begin
                result = {{(xlen-1){1'b0}}, lessUnsigned};
            end
            aluSll: result = a << shamt;
            aluSrl: result = a >> shamt;
            aluSra: begin
                // Arithmetic shift keeps the sign bit
                result = $unsigned($signed(a) >>> shamt);
            end
            default: result = a + b;
        endcase
    end

endmodule

/* source/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::instrU     instr,
    input  logic             busAck,
    output rvPkg::ctrlWordT  ctrl,
    output logic             busCyc,
    output logic             busWe,
    output logic [31:0]      instRetired
);
    import rvPkg::*;

    stateT state;
    stateT stateNext;
    logic  running;                         // Set from the first cycle after reset
    logic  isRegReg;
    logic  isRegImm;
    logic  isLoad;
    logic  isStore;
    logic  isMem;
    logic  busDone;
    aluOpT decodedOp;

    assign isRegReg = (instr.r.opcode == opRegReg);
    assign isRegImm = (instr.r.opcode == opRegImm);
    assign isLoad   = (instr.r.opcode == opLoad);
    assign isStore  = (instr.r.opcode == opStore);
    assign isMem    = isLoad | isStore;

    // Bus cycle is open only in fetch and memory
    assign busCyc  = running && (state == stateFetch || state == stateMemory);
    assign busWe   = (state == stateMemory) && isStore;
    assign busDone = busCyc && busAck;

    // ALU operation from funct3, funct7 picks SUB and SRA
    always_comb begin
        decodedOp = aluAdd;
        if (isRegReg || isRegImm) begin
            case (instr.r.funct3)
                3'b000: begin
                    if (isRegReg && instr.r.funct7[5]) begin
                        decodedOp = aluSub;
                    end else begin
                        decodedOp = aluAdd;
                    end
                end
                3'b001: decodedOp = aluSll;
                3'b010: decodedOp = aluSlt;
                3'b011: decodedOp = aluSltu;
                3'b100: decodedOp = aluXor;
                3'b101: decodedOp = instr.r.funct7[5] ? aluSra : aluSrl; // SRAI uses imm[10]
                3'b110: decodedOp = aluOr;
                default: decodedOp = aluAnd;
            endcase
        end
    end

    // Next state sequencing
    always_comb begin
        stateNext = state;
        case (state)
            stateFetch: begin
                if (busDone) begin
                    stateNext = stateDecode;
                end
            end
            stateDecode: stateNext = stateExecute;
            stateExecute: stateNext = isMem ? stateMemory : stateWriteback;
            stateMemory: begin
                if (busDone) begin
                    stateNext = stateWriteback;
                end
            end
            default: stateNext = stateFetch;   // Writeback and unused codes
        endcase
    end

    // Control word, every field set in every state
    always_comb begin
        ctrl.aluSrcImm  = !isRegReg;        // Imm for I-type, LW and SW
        ctrl.immStore   = isStore;
        ctrl.aluOp      = decodedOp;
        ctrl.wbFromMem  = isLoad;
        ctrl.irLoad     = (state == stateFetch) && busDone;
        ctrl.regLoad    = (state == stateDecode);
        ctrl.aluLatch   = (state == stateExecute);
        ctrl.busAddrSel = (state == stateMemory);
        ctrl.pcAdvance  = (state == stateWriteback);
        // Unknown opcodes and SW write nothing back
        ctrl.regWrite   = (state == stateWriteback) && (isRegReg || isRegImm || isLoad);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stateFetch;
            running <= 1'b0;
        end else begin
            state   <= stateNext;
            running <= 1'b1;
        end
    end

    // One count per instruction leaving writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            instRetired <= '0;
        end else if (state == stateWriteback) begin
            instRetired <= instRetired + 32'd1;
        end
    end

endmodule

/* source/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic          clk,
    input  logic          rst,
    output rvPkg::wbReqT  busReq,
    input  rvPkg::wbRspT  busRsp,
    output logic [31:0]   instRetired
);
    import rvPkg::*;

    ctrlWordT        ctrl;
    instrU           instr;
    logic            busCyc;
    logic            busWe;
    logic [xlen-1:0] busAdr;
    logic [xlen-1:0] busDat;

    // Word accesses only, strobe follows cycle
    assign busReq = '{cyc: busCyc, stb: busCyc, we: busWe, adr: busAdr, dat: busDat, sel: '1};

    controlUnit controlUnit_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .busAck      (busRsp.ack),
        .ctrl        (ctrl),
        .busCyc      (busCyc),
        .busWe       (busWe),
        .instRetired (instRetired)
    );

    dataPath dataPath_i (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl),
        .busRsp (busRsp),
        .instr  (instr),
        .busAdr (busAdr),
        .busDat (busDat)
    );

endmodule

/* source/dataPath.sv */
`timescale 1ns/1ps

module dataPath (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::ctrlWordT  ctrl,
    input  rvPkg::wbRspT     busRsp,
    output rvPkg::instrU     instr,
    output logic [31:0]      busAdr,
    output logic [31:0]      busDat
);
    import rvPkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] opA;                   // rs1 operand register
    logic [xlen-1:0] opB;                   // rs2 operand register
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] memData;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] wbData;

    // Sign-extended immediate through the I or S view
    always_comb begin
        if (ctrl.immStore) begin
            imm = {{(xlen-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
        end else begin
            imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
        end
    end

    assign aluB   = ctrl.aluSrcImm ? imm : opB;
    assign wbData = ctrl.wbFromMem ? memData : aluResult;

    assign busAdr = ctrl.busAddrSel ? aluResult : pc;
    assign busDat = opB;                    // SW data is rs2

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pcAdvance) begin
            pc <= pc + xlen'(4);
        end
    end

    // Instruction register loads in the fetch ack cycle
    always_ff @(posedge clk) begin
        if (ctrl.irLoad) begin
            instr <= busRsp.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.regLoad) begin
            opA <= rd1;
            opB <= rd2;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.aluLatch) begin
            aluResult <= aluOut;
        end
    end

    // Read data of a data access, captured on ack
    always_ff @(posedge clk) begin
        if (busRsp.ack && ctrl.busAddrSel) begin
            memData <= busRsp.dat;
        end
    end

    regFile regFile_i (
        .clk (clk),
        .rst (rst),
        .rs1 (instr.r.rs1),
        .rs2 (instr.r.rs2),
        .rd  (instr.r.rd),
        .we  (ctrl.regWrite),
        .wd  (wbData),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    aluUnit aluUnit_i (
        .a      (opA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluOut)
    );

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [1:31];               // No storage behind x0

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // x0 always reads zero
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* source/rvPkg.sv */
package rvPkg;

    localparam int xlen = 32;

    // Major opcodes of the supported groups
    localparam logic [6:0] opRegReg = 7'b0110011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrRT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instrIT;

    typedef struct packed {
        logic [6:0] immHi;                  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;                  // imm[4:0]
        logic [6:0] opcode;
    } instrST;

    // One instruction word, three format views
    typedef union packed {
        instrRT r;
        instrIT i;
        instrST s;
    } instrU;

    typedef struct packed {
        logic  aluSrcImm;                   // Operand B from immediate
        logic  immStore;                    // S-format immediate
        aluOpT aluOp;
        logic  irLoad;
        logic  regLoad;                     // Latch register file outputs
        logic  aluLatch;
        logic  regWrite;
        logic  wbFromMem;                   // Writeback from bus read data
        logic  pcAdvance;
        logic  busAddrSel;                  // 1 selects ALU result, 0 the PC
    } ctrlWordT;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [xlen-1:0]   adr;
        logic [xlen-1:0]   dat;
        logic [xlen/8-1:0] sel;
    } wbReqT;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat;
    } wbRspT;

    typedef enum logic [2:0] {
        stateFetch,
        stateDecode,
        stateExecute,
        stateMemory,
        stateWriteback
    } stateT;

endpackage
